// ==== source/debug_cfg.svh ====
`ifndef DEBUG_CFG_SVH
`define DEBUG_CFG_SVH

////////////////////////////////////////////////////////////////////////
// uart timing
////////////////////////////////////////////////////////////////////////

`define DBG_CLKS_PER_BIT 16 // clocks per serial bit

////////////////////////////////////////////////////////////////////////
// instruction memory and opcodes
////////////////////////////////////////////////////////////////////////

`define DBG_ADDR_W 6 // 64 instruction words
`define DBG_HALT_OPCODE 6'b111111

// host command bytes
`define DBG_CMD_START 8'h01
`define DBG_CMD_CONTINUOUS 8'h02
`define DBG_CMD_STEP_MODE 8'h03
`define DBG_CMD_REPROGRAM 8'h05
`define DBG_CMD_STEP 8'h06

`endif

// ==== source/debug_pkg.sv ====
`default_nettype none

`include "debug_cfg.svh"

package debug_pkg;

	// one instruction word, seen as bytes or as fields
	typedef union packed {
		logic [3:0][7:0] bytes; // byte 0 arrives first
		struct packed {
			logic [5:0] opcode;
			logic [25:0] rest;
		} fields;
	} inst_word_u;

	// received byte with its done tick
	typedef struct packed {
		logic done;
		logic [7:0] data;
	} rx_byte_t;

	typedef struct packed {
		logic enable; // one fetch allowed
		logic clear;  // back to address zero
	} core_ctrl_t;

	typedef struct packed {
		logic [`DBG_ADDR_W-1:0] pc;
		logic [15:0] cycles;
		logic halted;
	} core_status_t;

	typedef struct packed {
		logic strobe;
		logic [`DBG_ADDR_W-1:0] addr;
		inst_word_u word;
	} mem_write_t;

endpackage

`default_nettype wire

// ==== source/uart_rx.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "debug_cfg.svh"

module uart_rx
(
	input  logic clk,
	input  logic reset,
	input  logic rx_serial,
	output debug_pkg::rx_byte_t rx_byte
);

	localparam int cnt_w = $clog2(`DBG_CLKS_PER_BIT);

	typedef enum logic [1:0] {st_idle, st_start, st_data, st_stop} state_t;

	state_t state;
	logic [1:0] sync_q;
	logic [cnt_w-1:0] cnt_q;
	logic [2:0] bit_idx;
	logic [7:0] shift_q;
	logic done_q;

	// two flops against metastability
	always_ff @(posedge clk)
	begin
		if (reset)
			sync_q <= 2'b11; // line idles high
		else
			sync_q <= {sync_q[0], rx_serial};
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= st_idle;
			cnt_q <= '0;
			bit_idx <= '0;
			done_q <= 1'b0;
		end
		else
		begin
			done_q <= 1'b0;
			case (state)
				st_idle:
					if (!sync_q[1])
					begin
						state <= st_start;
						cnt_q <= cnt_w'(`DBG_CLKS_PER_BIT / 2 - 1); // half bit to the middle
					end
				st_start:
					if (cnt_q == '0)
					begin
						bit_idx <= '0;
						cnt_q <= cnt_w'(`DBG_CLKS_PER_BIT - 1);
						// start bit gone high again means a glitch
						state <= sync_q[1] ? st_idle : st_data;
					end
					else
						cnt_q <= cnt_q - 1'b1;
				st_data:
					if (cnt_q == '0)
					begin
						shift_q <= {sync_q[1], shift_q[7:1]}; // lsb first
						cnt_q <= cnt_w'(`DBG_CLKS_PER_BIT - 1);
						bit_idx <= bit_idx + 3'd1;
						if (bit_idx == 3'd7)
							state <= st_stop;
					end
					else
						cnt_q <= cnt_q - 1'b1;
				st_stop:
					if (cnt_q == '0)
					begin
						done_q <= 1'b1; // tick one cycle after mid stop bit
						state <= st_idle;
					end
					else
						cnt_q <= cnt_q - 1'b1;
				default:
					state <= st_idle;
			endcase
		end
	end

	assign rx_byte = '{done: done_q, data: shift_q};

endmodule

`default_nettype wire

// ==== source/uart_tx.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "debug_cfg.svh"

module uart_tx
(
	input  logic clk,
	input  logic reset,
	input  logic tx_start,
	input  logic [7:0] tx_data,
	output logic tx_serial,
	output logic tx_done
);

	localparam int cnt_w = $clog2(`DBG_CLKS_PER_BIT);

	typedef enum logic [1:0] {st_idle, st_start, st_data, st_stop} state_t;

	state_t state;
	logic [cnt_w-1:0] cnt_q;
	logic [2:0] bit_idx;
	logic [7:0] shift_q;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= st_idle;
			cnt_q <= '0;
			bit_idx <= '0;
			tx_serial <= 1'b1;
		end
		else
		begin
			if (state != st_idle)
				cnt_q <= cnt_q - 1'b1;
			case (state)
				st_idle:
					if (tx_start)
					begin
						shift_q <= tx_data; // byte taken once per frame
						tx_serial <= 1'b0;
						cnt_q <= cnt_w'(`DBG_CLKS_PER_BIT - 1);
						bit_idx <= '0;
						state <= st_start;
					end
				st_start:
					if (cnt_q == '0)
					begin
						tx_serial <= shift_q[0];
						shift_q <= shift_q >> 1;
						state <= st_data;
					end
				st_data:
					if (cnt_q == '0)
					begin
						bit_idx <= bit_idx + 3'd1;
						if (bit_idx == 3'd7)
						begin
							tx_serial <= 1'b1; // stop bit
							state <= st_stop;
						end
						else
						begin
							tx_serial <= shift_q[0];
							shift_q <= shift_q >> 1;
						end
					end
				st_stop:
					if (cnt_q == '0)
						state <= st_idle;
				default:
					state <= st_idle;
			endcase
		end
	end

	assign tx_done = (state == st_stop) && (cnt_q == '0); // last cycle of stop bit

	// sender must not change the byte before its frame is done
	a_data_held: assert property (@(posedge clk) disable iff (reset)
		(tx_start && !tx_done) |=> (!tx_start || $stable(tx_data)));

endmodule

`default_nettype wire

// ==== source/debug_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "debug_cfg.svh"

module debug_unit
(
	input  logic clk,
	input  logic reset,
	input  debug_pkg::rx_byte_t rx_byte,
	input  logic tx_done,
	output logic tx_start,
	output logic [7:0] tx_data,
	output debug_pkg::mem_write_t mem_write,
	output debug_pkg::core_ctrl_t core_ctrl,
	input  debug_pkg::core_status_t core_status
);

	typedef enum logic [2:0] {
		st_idle,
		st_prog,
		st_wait,
		st_cont,
		st_step,
		st_step_run,
		st_step_settle,
		st_send
	} state_t;

	state_t state;
	logic [1:0] byte_idx;
	logic [`DBG_ADDR_W-1:0] addr_q;
	debug_pkg::inst_word_u word_q;
	debug_pkg::inst_word_u word_next;
	debug_pkg::mem_write_t write_q;
	logic clear_q;
	logic from_step;  // where to go after the report
	logic [1:0] send_idx;
	logic [3:0][7:0] report_q;
	logic last_write;
	logic enter_send;

	////////////////////////////////////////////////////////////////////
	// word assembly
	////////////////////////////////////////////////////////////////////

	always_comb
	begin
		word_next = word_q;
		word_next.bytes[byte_idx] = rx_byte.data;
	end

	always_ff @(posedge clk)
	begin
		if (state == st_prog && rx_byte.done)
			word_q <= word_next;
	end

	// halt word or top address ends programming
	assign last_write = write_q.strobe &&
		(write_q.word.fields.opcode == `DBG_HALT_OPCODE || write_q.addr == '1);

	////////////////////////////////////////////////////////////////////
	// command fsm
	////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= st_idle;
			byte_idx <= '0;
			addr_q <= '0;
			write_q.strobe <= 1'b0;
			clear_q <= 1'b0;
			from_step <= 1'b0;
			send_idx <= '0;
		end
		else
		begin
			write_q.strobe <= 1'b0;
			clear_q <= 1'b0;
			case (state)
				st_idle:
					if (rx_byte.done && rx_byte.data == `DBG_CMD_START)
					begin
						byte_idx <= '0;
						addr_q <= '0;
						state <= st_prog;
					end
				st_prog:
					if (last_write)
						state <= st_wait;
					else if (rx_byte.done)
					begin
						byte_idx <= byte_idx + 2'd1;
						if (byte_idx == 2'd3)
						begin
							write_q.strobe <= 1'b1;
							write_q.addr <= addr_q;
							write_q.word <= word_next;
							addr_q <= addr_q + 1'b1;
						end
					end
				st_wait:
					if (rx_byte.done)
						case (rx_byte.data)
							`DBG_CMD_CONTINUOUS:
							begin
								from_step <= 1'b0;
								state <= st_cont;
							end
							`DBG_CMD_STEP_MODE:
								state <= st_step;
							`DBG_CMD_REPROGRAM:
							begin
								clear_q <= 1'b1;
								state <= st_idle;
							end
							default: ; // anything else is ignored
						endcase
				st_cont:
					if (core_status.halted)
						state <= st_send;
				st_step:
					if (rx_byte.done && rx_byte.data == `DBG_CMD_STEP)
					begin
						from_step <= 1'b1;
						state <= st_step_run;
					end
					else if (rx_byte.done && rx_byte.data == `DBG_CMD_REPROGRAM)
					begin
						clear_q <= 1'b1;
						state <= st_idle;
					end
				st_step_run:
					state <= st_step_settle; // the one enabled cycle
				st_step_settle:
					state <= st_send;
				st_send:
					if (tx_done)
					begin
						send_idx <= send_idx + 2'd1; // wraps to 0 after byte 3
						if (send_idx == 2'd3)
							state <= from_step ? st_step : st_wait;
					end
				default:
					state <= st_idle;
			endcase
		end
	end

	////////////////////////////////////////////////////////////////////
	// report
	////////////////////////////////////////////////////////////////////

	assign enter_send = (state == st_cont && core_status.halted) || (state == st_step_settle);

	// snapshot so the bytes stay steady while they go out
	always_ff @(posedge clk)
	begin
		if (enter_send)
		begin
			report_q[0] <= {{(8 - `DBG_ADDR_W){1'b0}}, core_status.pc};
			report_q[1] <= core_status.cycles[7:0];
			report_q[2] <= core_status.cycles[15:8];
			report_q[3] <= {7'b0, core_status.halted};
		end
	end

	assign tx_start = (state == st_send);
	assign tx_data = report_q[send_idx];
	assign mem_write = write_q;
	assign core_ctrl = '{enable: (state == st_cont) || (state == st_step_run), clear: clear_q};

	a_write_in_prog: assert property (@(posedge clk) disable iff (reset)
		mem_write.strobe |-> state == st_prog);

	a_no_run_while_tx: assert property (@(posedge clk) disable iff (reset)
		core_ctrl.enable |-> !tx_start);

endmodule

`default_nettype wire

// ==== source/inst_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "debug_cfg.svh"

module inst_mem
(
	input  logic clk,
	input  debug_pkg::mem_write_t mem_write,
	input  logic [`DBG_ADDR_W-1:0] read_addr,
	output debug_pkg::inst_word_u read_word
);

	localparam int depth = 2 ** `DBG_ADDR_W;

	debug_pkg::inst_word_u mem [depth];

	// single write port from the loader
	always_ff @(posedge clk)
	begin
		if (mem_write.strobe)
			mem[mem_write.addr] <= mem_write.word;
	end

	assign read_word = mem[read_addr]; // combinational fetch

endmodule

`default_nettype wire

// ==== source/fetch_core.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "debug_cfg.svh"

module fetch_core
(
	input  logic clk,
	input  logic reset,
	input  debug_pkg::core_ctrl_t core_ctrl,
	input  debug_pkg::inst_word_u fetch_word,
	output logic [`DBG_ADDR_W-1:0] fetch_addr,
	output debug_pkg::core_status_t core_status
);

	logic [`DBG_ADDR_W-1:0] pc;
	logic [15:0] cycles;
	logic halted;
	logic is_halt;

	assign is_halt = (fetch_word.fields.opcode == `DBG_HALT_OPCODE);

	always_ff @(posedge clk)
	begin
		if (reset || core_ctrl.clear)
		begin
			pc <= '0;
			cycles <= '0;
			halted <= 1'b0;
		end
		else if (core_ctrl.enable && !halted)
		begin
			// halt word freezes pc on its own address
			if (is_halt)
				halted <= 1'b1;
			else
			begin
				pc <= pc + 1'b1;
				cycles <= cycles + 16'd1;
			end
		end
	end

	assign fetch_addr = pc;
	assign core_status = '{pc: pc, cycles: cycles, halted: halted};

	a_pc_frozen: assert property (@(posedge clk) disable iff (reset)
		(halted && !core_ctrl.clear) |=> $stable(pc));

endmodule

`default_nettype wire

// ==== source/debug_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "debug_cfg.svh"

module debug_top
(
	input  logic clk,
	input  logic reset,
	input  logic rx_serial,
	output logic tx_serial
);

	debug_pkg::rx_byte_t rx_byte;
	debug_pkg::mem_write_t mem_write;
	debug_pkg::core_ctrl_t core_ctrl;
	debug_pkg::core_status_t core_status;
	debug_pkg::inst_word_u fetch_word;
	logic [`DBG_ADDR_W-1:0] fetch_addr;
	logic tx_start;
	logic tx_done;
	logic [7:0] tx_data;

	////////////////////////////////////////////////////////////////////
	// serial side
	////////////////////////////////////////////////////////////////////

	uart_rx uart_rx_inst (
		.clk       (clk),
		.reset     (reset),
		.rx_serial (rx_serial),
		.rx_byte   (rx_byte)
	);

	uart_tx uart_tx_inst (
		.clk       (clk),
		.reset     (reset),
		.tx_start  (tx_start),
		.tx_data   (tx_data),
		.tx_serial (tx_serial),
		.tx_done   (tx_done)
	);

	debug_unit debug_unit_inst (
		.clk         (clk),
		.reset       (reset),
		.rx_byte     (rx_byte),
		.tx_done     (tx_done),
		.tx_start    (tx_start),
		.tx_data     (tx_data),
		.mem_write   (mem_write),
		.core_ctrl   (core_ctrl),
		.core_status (core_status)
	);

	// memory and core
	inst_mem inst_mem_inst (
		.clk       (clk),
		.mem_write (mem_write),
		.read_addr (fetch_addr),
		.read_word (fetch_word)
	);

	fetch_core fetch_core_inst (
		.clk         (clk),
		.reset       (reset),
		.core_ctrl   (core_ctrl),
		.fetch_word  (fetch_word),
		.fetch_addr  (fetch_addr),
		.core_status (core_status)
	);

endmodule

`default_nettype wire

// ==== test/tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen
(
	output logic clk,
	output logic reset
);

	localparam int reset_cycles = 16;

	initial
	begin
		clk = 1'b0;
		forever
			#4 clk = ~clk; // 8 ns period
	end

	// release just after a rising edge
	initial
	begin
		reset = 1'b1;
		repeat (reset_cycles) @(posedge clk);
		#1 reset = 1'b0;
	end

endmodule

`default_nettype wire

// ==== test/debug_top_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "debug_cfg.svh"

module debug_top_tb;

	localparam int bit_clks = `DBG_CLKS_PER_BIT;
	localparam int report_wait = 20000; // cycles allowed for a report start bit
	localparam int reset_wait = 64;
	localparam int num_words = 2 ** `DBG_ADDR_W;

	logic clk;
	logic reset;
	logic rx_serial;
	logic tx_serial;

	integer seed;
	int errors;
	int checks;
	int tests;
	int test_errors;
	logic [7:0] rx_report [4];

	tb_clock_gen clock_gen_inst (
		.clk   (clk),
		.reset (reset)
	);

	debug_top debug_top_inst (
		.clk       (clk),
		.reset     (reset),
		.rx_serial (rx_serial),
		.tx_serial (tx_serial)
	);

	//////////////////////////////////////////////////////////////////////
	// host model
	//////////////////////////////////////////////////////////////////////

	task automatic stop_on_timeout(input string what);
		$display("timeout while waiting for %s", what);
		$display("*** FAILED ***");
		$finish;
	endtask

	// start bit, eight data bits lsb first, stop bit
	task automatic send_byte(input logic [7:0] value);
		logic [9:0] frame;
		frame = {1'b1, value, 1'b0};
		for (int i = 0; i < 10; i++)
		begin
			@(posedge clk);
			#1 rx_serial = frame[i];
			repeat (bit_clks - 1) @(posedge clk);
		end
	endtask

	task automatic receive_report();
		int wait_cycles;
		logic [7:0] value;
		for (int b = 0; b < 4; b++)
		begin
			wait_cycles = 0;
			@(negedge clk);
			while (tx_serial === 1'b1 && wait_cycles < report_wait)
			begin
				@(negedge clk);
				wait_cycles++;
			end
			if (tx_serial !== 1'b0)
				stop_on_timeout($sformatf("start bit of report byte %0d", b));
			repeat (bit_clks / 2) @(negedge clk); // middle of start bit
			for (int i = 0; i < 8; i++)
			begin
				repeat (bit_clks) @(negedge clk);
				value[i] = tx_serial;
			end
			repeat (bit_clks) @(negedge clk);
			check_byte("tx_serial stop bit", {7'b0, tx_serial}, 8'h01);
			rx_report[b] = value;
		end
	endtask

	function automatic logic is_command(input logic [7:0] value);
		return value == `DBG_CMD_START || value == `DBG_CMD_CONTINUOUS ||
			value == `DBG_CMD_STEP_MODE || value == `DBG_CMD_REPROGRAM ||
			value == `DBG_CMD_STEP;
	endfunction

	task automatic send_noise(input int count);
		logic [7:0] value;
		for (int i = 0; i < count; i++)
		begin
			value = $random(seed);
			if (is_command(value))
				value = value + 8'h10; // moves clear of every command byte
			send_byte(value);
		end
	endtask

	// random words, then a halt word if asked for
	task automatic load_program(input int n_random, input logic with_halt);
		logic [31:0] word;
		int total;
		total = with_halt ? n_random + 1 : n_random;
		send_byte(`DBG_CMD_START);
		for (int i = 0; i < total; i++)
		begin
			word = $random(seed);
			if (i == n_random)
				word[31:26] = `DBG_HALT_OPCODE;
			else if (word[31:26] == `DBG_HALT_OPCODE)
				word[31:26] = 6'h00;
			for (int b = 0; b < 4; b++)
				send_byte(word[8*b +: 8]);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// checking
	//////////////////////////////////////////////////////////////////////

	// pc and count follow the fetches until the halt word stops both
	function automatic logic [31:0] expected_report(input int steps, input int halt_addr);
		logic [15:0] pos;
		logic [7:0] status;
		pos = (steps < halt_addr) ? 16'(steps) : 16'(halt_addr);
		status = (steps > halt_addr) ? 8'h01 : 8'h00;
		return {status, pos[15:8], pos[7:0], pos[7:0]};
	endfunction

	task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
		checks++;
		assert (got === exp)
		else
		begin
			$display("CHECK FAILED %s: got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	// report may start before the command's stop bit is over
	task automatic command_with_report(input logic [7:0] cmd, input int steps,
		input int halt_addr);
		logic [31:0] exp;
		exp = expected_report(steps, halt_addr);
		fork
			send_byte(cmd);
			receive_report();
		join
		check_byte("report pc", rx_report[0], exp[7:0]);
		check_byte("report cycles low", rx_report[1], exp[15:8]);
		check_byte("report cycles high", rx_report[2], exp[23:16]);
		check_byte("report status", rx_report[3], exp[31:24]);
	endtask

	task automatic expect_silence(input int cycles);
		logic seen;
		seen = 1'b0;
		checks++;
		for (int i = 0; i < cycles && !seen; i++)
		begin
			@(negedge clk);
			assert (tx_serial === 1'b1)
			else
			begin
				$display("CHECK FAILED tx_serial: got %h expected %h", tx_serial, 1'b1);
				errors++;
				seen = 1'b1;
			end
		end
	endtask

	task automatic end_test(input string name);
		tests++;
		$display("test %0d %s: %0d errors", tests, name, errors - test_errors);
		test_errors = errors;
	endtask

	//////////////////////////////////////////////////////////////////////
	// test sequence
	//////////////////////////////////////////////////////////////////////

	initial
	begin
		int wait_cycles;
		seed = 32'hdeed_abba;
		rx_serial = 1'b1;
		errors = 0;
		checks = 0;
		tests = 0;
		test_errors = 0;
		wait_cycles = 0;
		@(posedge clk);
		while (reset !== 1'b0 && wait_cycles < reset_wait)
		begin
			@(posedge clk);
			wait_cycles++;
		end
		if (reset !== 1'b0)
			stop_on_timeout("reset release");

		// halt at address 4
		load_program(4, 1'b1);
		command_with_report(`DBG_CMD_CONTINUOUS, 5, 4);
		end_test("continuous run");

		send_byte(`DBG_CMD_REPROGRAM);
		load_program(7, 1'b1);
		send_byte(`DBG_CMD_STEP_MODE);
		for (int k = 1; k <= 3; k++)
			command_with_report(`DBG_CMD_STEP, k, 7);
		end_test("single steps");

		for (int k = 4; k <= 10; k++)
			command_with_report(`DBG_CMD_STEP, k, 7); // sticks from step 8 on
		end_test("steps past halt");

		send_byte(`DBG_CMD_REPROGRAM);
		load_program(3, 1'b1);
		fork
			send_noise(6);
			expect_silence(6 * 10 * bit_clks + 400);
		join
		command_with_report(`DBG_CMD_CONTINUOUS, 4, 3);
		end_test("ignored bytes");

		// full memory ends programming at the last address
		send_byte(`DBG_CMD_REPROGRAM);
		load_program(num_words, 1'b0);
		send_byte(`DBG_CMD_REPROGRAM);
		load_program(2, 1'b1);
		command_with_report(`DBG_CMD_CONTINUOUS, 3, 2);
		end_test("full memory and clear");

		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+source
source/debug_pkg.sv
source/uart_rx.sv
source/uart_tx.sv
source/debug_unit.sv
source/inst_mem.sv
source/fetch_core.sv
source/debug_top.sv
test/tb_clock_gen.sv
test/debug_top_tb.sv
